// File: design/alu_pkg.sv
package alu_pkg;

   // datapath widths
   localparam int XLEN    = 64;
   localparam int SHAMT_W = 6;    // low bits of b used as shift amount
   localparam int COUNT_W = 7;    // count range 0..XLEN

   // **********************************************************
   // operation codes
   // **********************************************************
   typedef enum logic [4:0] {
      op_add  = 5'd0,
      op_sub  = 5'd1,
      op_and  = 5'd2,
      op_or   = 5'd3,
      op_xor  = 5'd4,
      op_sll  = 5'd5,
      op_srl  = 5'd6,
      op_sra  = 5'd7,
      op_slt  = 5'd8,
      op_sltu = 5'd9,
      op_min  = 5'd10,
      op_max  = 5'd11,
      op_minu = 5'd12,
      op_maxu = 5'd13,
      op_clz  = 5'd14,
      op_ctz  = 5'd15,
      op_cpop = 5'd16
   } alu_op_e;

   // one request, 133 bits
   typedef struct packed {
      alu_op_e         op;
      logic [XLEN-1:0] a;
      logic [XLEN-1:0] b;
   } alu_req_t;

endpackage

// File: design/alu_operand_stage.sv
`timescale 1ns/1ps

module alu_operand_stage
   import alu_pkg::*;
(
   input  logic            clk,
   input  logic            rst_n_i,
   input  logic            valid_i,
   input  alu_req_t        req_i,
   output alu_req_t        req_q_o,
   output logic            valid_q_o,
   output logic [XLEN-1:0] count_src_o
);

   logic [XLEN-1:0] a_rev;

   // **********************************************************
   // operand registers
   // **********************************************************
   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
         valid_q_o <= 1'b0;
      else
         valid_q_o <= valid_i;    // result valid one cycle later
   end

   // payload only loads on a new request
   always_ff @(posedge clk)
   begin
      if (valid_i)
         req_q_o <= req_i;
   end

   // **********************************************************
   // count source for the segment counters
   // **********************************************************
   always_comb
   begin
      for (int i = 0; i < XLEN; i++)
         a_rev[i] = req_q_o.a[XLEN-1-i];
   end

   // ctz turns into a leading zero count of the reversed operand
   assign count_src_o = (req_q_o.op == op_ctz) ? a_rev : req_q_o.a;

   // opcode must decode to one of the supported operations
   op_known_a: assert property (
      @(posedge clk) disable iff (!rst_n_i)
      valid_i |-> req_i.op inside {op_add, op_sub, op_and, op_or, op_xor,
                                  op_sll, op_srl, op_sra, op_slt, op_sltu,
                                  op_min, op_max, op_minu, op_maxu,
                                  op_clz, op_ctz, op_cpop}
   );

endmodule

// File: design/bit_segment_counter.sv
`timescale 1ns/1ps

module bit_segment_counter
#(
   parameter  int SEG_W = 16,
   localparam int CNT_W = $clog2(SEG_W) + 1
) (
   input  logic [SEG_W-1:0] seg_i,
   output logic [CNT_W-1:0] lz_o,
   output logic [CNT_W-1:0] pop_o,
   output logic             zero_o
);

   // leading zeros, highest set bit decides
   always_comb
   begin
      lz_o = CNT_W'(SEG_W);    // empty slice
      for (int i = 0; i < SEG_W; i++)
      begin
         if (seg_i[i])
            lz_o = CNT_W'(SEG_W - 1 - i);
      end
   end

   // population count
   always_comb
   begin
      pop_o = '0;
      for (int i = 0; i < SEG_W; i++)
         pop_o = pop_o + CNT_W'(seg_i[i]);
   end

   assign zero_o = ~|seg_i;

endmodule

// File: design/segment_merge.sv
`timescale 1ns/1ps

module segment_merge
   import alu_pkg::*;
#(
   parameter  int SEG_W   = 16,
   localparam int NUM_SEG = XLEN / SEG_W,
   localparam int CNT_W   = $clog2(SEG_W) + 1
) (
   input  logic [NUM_SEG-1:0][CNT_W-1:0] seg_lz_i,
   input  logic [NUM_SEG-1:0][CNT_W-1:0] seg_pop_i,
   input  logic [NUM_SEG-1:0]            seg_zero_i,
   input  alu_op_e                       op_i,
   output logic [COUNT_W-1:0]            count_value_o
);

   logic [COUNT_W-1:0] lz_sum;
   logic [COUNT_W-1:0] pop_sum;

   // **********************************************************
   // leading zero walk, segment 0 is the top slice
   // **********************************************************
   always_comb
   begin : lz_walk
      logic found;
      lz_sum = '0;
      found  = 1'b0;
      for (int k = 0; k < NUM_SEG; k++)
      begin
         if (!found)
            lz_sum = lz_sum + COUNT_W'(seg_lz_i[k]);    // empty slice adds SEG_W
         found = found | ~seg_zero_i[k];
      end
   end

   always_comb
   begin
      pop_sum = '0;
      for (int k = 0; k < NUM_SEG; k++)
         pop_sum = pop_sum + COUNT_W'(seg_pop_i[k]);
   end

   assign count_value_o = (op_i == op_cpop) ? pop_sum : lz_sum;

   // segment counts together never pass the word width
   count_range_a: assert final (
      $isunknown(count_value_o) || (count_value_o <= COUNT_W'(XLEN))
   );

endmodule

// File: design/alu_execute.sv
`timescale 1ns/1ps

module alu_execute
   import alu_pkg::*;
(
   input  alu_req_t           req_q_i,
   input  logic               valid_q_i,
   input  logic [COUNT_W-1:0] count_value_i,
   output logic [XLEN-1:0]    result_o
);

   logic [XLEN-1:0]    a;
   logic [XLEN-1:0]    b;
   logic [XLEN-1:0]    bm;
   logic [XLEN-1:0]    sum;
   logic               cout;
   logic               ov;
   logic               is_sub;
   logic               unsign;
   logic               lt;
   logic               sel_a;
   logic [XLEN-1:0]    minmax;
   logic [SHAMT_W-1:0] shamt;
   logic [SHAMT_W:0]   shift_cnt;
   logic [2*XLEN-1:0]  shift_in;
   logic [2*XLEN-1:0]  shift_out;

   assign a = req_q_i.a;
   assign b = req_q_i.b;

   // **********************************************************
   // adder, shared by add, sub and all compares
   // **********************************************************
   assign is_sub = req_q_i.op inside {op_sub, op_slt, op_sltu,
                                      op_min, op_max, op_minu, op_maxu};
   assign unsign = req_q_i.op inside {op_sltu, op_minu, op_maxu};

   assign bm = is_sub ? ~b : b;
   assign {cout, sum} = {1'b0, a} + {1'b0, bm} + {{XLEN{1'b0}}, is_sub};

   assign ov = (~a[XLEN-1] & ~bm[XLEN-1] &  sum[XLEN-1]) |
               ( a[XLEN-1] &  bm[XLEN-1] & ~sum[XLEN-1]);

   // no borrow out means a >= b unsigned
   assign lt = unsign ? ~cout : (sum[XLEN-1] ^ ov);

   // min keeps a when a < b, max when not
   assign sel_a  = lt ^ (req_q_i.op inside {op_max, op_maxu});
   assign minmax = sel_a ? a : b;

   // **********************************************************
   // funnel shifter
   // **********************************************************
   assign shamt = b[SHAMT_W-1:0];

   always_comb
   begin
      case (req_q_i.op)
         op_sll  : shift_in = {a, {XLEN{1'b0}}};
         op_sra  : shift_in = {{XLEN{a[XLEN-1]}}, a};
         default : shift_in = {{XLEN{1'b0}}, a};       // srl
      endcase
   end

   // left shift as a right shift by 64 - shamt
   assign shift_cnt = (req_q_i.op == op_sll) ? ((SHAMT_W+1)'(XLEN) - {1'b0, shamt})
                                              : {1'b0, shamt};
   assign shift_out = shift_in >> shift_cnt;

   // **********************************************************
   // result select
   // **********************************************************
   always_comb
   begin
      case (req_q_i.op)
         op_add, op_sub          : result_o = sum;
         op_and                  : result_o = a & b;
         op_or                   : result_o = a | b;
         op_xor                  : result_o = a ^ b;
         op_sll, op_srl, op_sra  : result_o = shift_out[XLEN-1:0];
         op_slt, op_sltu         : result_o = {{(XLEN-1){1'b0}}, lt};
         op_min, op_max,
         op_minu, op_maxu        : result_o = minmax;
         op_clz, op_ctz, op_cpop : result_o = {{(XLEN-COUNT_W){1'b0}}, count_value_i};
         default                 : result_o = '0;
      endcase
   end

   // a registered request must give a clean result through every path
   result_known_a: assert final (
      (valid_q_i !== 1'b1) || !$isunknown(result_o)
   );

endmodule

// File: design/alu_top.sv
`timescale 1ns/1ps

module alu_top
   import alu_pkg::*;
#(
   parameter  int SEG_W   = 16,
   localparam int NUM_SEG = XLEN / SEG_W,
   localparam int CNT_W   = $clog2(SEG_W) + 1
) (
   input  logic            clk,
   input  logic            rst_n_i,
   input  logic            valid_i,
   input  alu_req_t        req_i,
   output logic            result_valid_o,
   output logic [XLEN-1:0] result_o
);

   alu_req_t                   req_q;
   logic [XLEN-1:0]            count_src;
   logic [NUM_SEG-1:0][CNT_W-1:0] seg_lz;
   logic [NUM_SEG-1:0][CNT_W-1:0] seg_pop;
   logic [NUM_SEG-1:0]         seg_zero;
   logic [COUNT_W-1:0]         count_value;

   alu_operand_stage operand_stage_i (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .valid_i     (valid_i),
      .req_i       (req_i),
      .req_q_o     (req_q),
      .valid_q_o   (result_valid_o),
      .count_src_o (count_src)
   );

   // **********************************************************
   // segment counters, segment 0 takes the top slice
   // **********************************************************
   for (genvar k = 0; k < NUM_SEG; k++)
   begin : g_seg
      bit_segment_counter #(
         .SEG_W (SEG_W)
      ) seg_cnt_i (
         .seg_i  (count_src[XLEN-1-k*SEG_W -: SEG_W]),
         .lz_o   (seg_lz[k]),
         .pop_o  (seg_pop[k]),
         .zero_o (seg_zero[k])
      );
   end

   segment_merge #(
      .SEG_W (SEG_W)
   ) merge_i (
      .seg_lz_i      (seg_lz),
      .seg_pop_i     (seg_pop),
      .seg_zero_i    (seg_zero),
      .op_i          (req_q.op),
      .count_value_o (count_value)
   );

   alu_execute execute_i (
      .req_q_i       (req_q),
      .valid_q_i     (result_valid_o),
      .count_value_i (count_value),
      .result_o      (result_o)
   );

endmodule

// File: bench/alu_checker.sv
`timescale 1ns/1ps

module alu_checker
   import alu_pkg::*;
#(
   parameter int NAME_W = 96
) (
   input  logic              clk,
   input  logic              rst_n_i,
   input  logic              req_valid_i,     // request sampled at this edge
   input  logic [XLEN-1:0]   exp_i,
   input  logic [NAME_W-1:0] name_i,
   input  logic              result_valid_i,
   input  logic [XLEN-1:0]   result_i,
   output int                mismatch_cnt_o,
   output int                protocol_cnt_o
);

   logic              pending;
   logic [XLEN-1:0]   exp_q;
   logic [NAME_W-1:0] name_q;

   initial
   begin
      mismatch_cnt_o = 0;
      protocol_cnt_o = 0;
   end

   // one cycle delay, matching the DUT latency
   always @(posedge clk)
   begin
      if (!rst_n_i)
         pending <= 1'b0;
      else
      begin
         pending <= req_valid_i;
         exp_q   <= exp_i;
         name_q  <= name_i;
      end
   end

   // **********************************************************
   // compare in the middle of the cycle, outputs are settled
   // **********************************************************
   always @(negedge clk)
   begin
      if (result_valid_i === 1'b1 && pending !== 1'b1)
      begin
         protocol_cnt_o++;
         $display("result valid at %0t ns without a pending request", $time);
      end
      else if (pending === 1'b1 && result_valid_i !== 1'b1)
      begin
         protocol_cnt_o++;
         $display("result for %0s missing at %0t ns", name_q, $time);
      end
      else if (pending === 1'b1 && result_i !== exp_q)
      begin
         mismatch_cnt_o++;
         $display("error %0s: expected %h, actual %h", name_q, exp_q, result_i);
      end
   end

endmodule

// File: bench/alu_tb.sv
`timescale 1ns/1ps

module alu_tb;
   import alu_pkg::*;

   localparam int NAME_W = 96;    // 12 characters
   localparam int MAX_VEC = 64;

   typedef struct packed {
      logic [NAME_W-1:0] name;
      alu_op_e           op;
      logic [XLEN-1:0]   a;
      logic [XLEN-1:0]   b;
      logic [XLEN-1:0]   exp;
      logic              idle;     // one idle cycle before this entry
   } vec_t;

   logic              clk;
   logic              rst_n_i;
   logic              valid_i;
   alu_req_t          req_i;
   logic              result_valid_o;
   logic [XLEN-1:0]   result_o;
   logic [XLEN-1:0]   exp_val;
   logic [NAME_W-1:0] name_val;
   logic              table_ready = 1'b0;
   int                mismatch_cnt;
   int                protocol_cnt;
   vec_t              vecs [MAX_VEC];
   int                n_vec = 0;
   int                n_idle = 0;
   integer            seed = 32'h8906;

   alu_top #(.SEG_W(16)) dut_i (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .valid_i        (valid_i),
      .req_i          (req_i),
      .result_valid_o (result_valid_o),
      .result_o       (result_o)
   );

   alu_checker #(.NAME_W(NAME_W)) checker_i (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .req_valid_i    (valid_i),
      .exp_i          (exp_val),
      .name_i         (name_val),
      .result_valid_i (result_valid_o),
      .result_i       (result_o),
      .mismatch_cnt_o (mismatch_cnt),
      .protocol_cnt_o (protocol_cnt)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // behavioral reference for the random entries
   function automatic logic [XLEN-1:0] expected_result(alu_op_e op, logic [XLEN-1:0] a,
                                                       logic [XLEN-1:0] b);
      int n;
      n = 0;
      case (op)
         op_add  : return a + b;
         op_sub  : return a - b;
         op_and  : return a & b;
         op_or   : return a | b;
         op_xor  : return a ^ b;
         op_sll  : return a << b[5:0];
         op_srl  : return a >> b[5:0];
         op_sra  : return $signed(a) >>> b[5:0];
         op_slt  : return 64'($signed(a) < $signed(b));
         op_sltu : return 64'(a < b);
         op_min  : return ($signed(a) < $signed(b)) ? a : b;
         op_max  : return ($signed(a) < $signed(b)) ? b : a;
         op_minu : return (a < b) ? a : b;
         op_maxu : return (a < b) ? b : a;
         op_clz  :
         begin
            while (n < XLEN && a[XLEN-1-n] == 1'b0)
               n++;
            return 64'(n);
         end
         op_ctz  :
         begin
            while (n < XLEN && a[n] == 1'b0)
               n++;
            return 64'(n);
         end
         op_cpop :
         begin
            for (int i = 0; i < XLEN; i++)
               n += a[i];
            return 64'(n);
         end
         default : return '0;
      endcase
   endfunction

   task automatic add_entry(input logic [NAME_W-1:0] name, input alu_op_e op,
                            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                            input logic [XLEN-1:0] exp, input logic idle);
      vecs[n_vec] = '{name, op, a, b, exp, idle};
      n_vec++;
      if (idle)
         n_idle++;
   endtask

   // **********************************************************
   // stimulus table
   // **********************************************************
   task automatic build_table();
      alu_op_e         op;
      logic [XLEN-1:0] ra;
      logic [XLEN-1:0] rb;
      add_entry("add_wrap", op_add, '1, 64'd1, 64'd0, 1'b0);
      add_entry("sub_wrap", op_sub, 64'd0, 64'd1, '1, 1'b0);
      add_entry("add_ovf", op_add, 64'h7FFF_FFFF_FFFF_FFFF, 64'd1, 64'h8000_0000_0000_0000, 1'b0);
      add_entry("and_bits", op_and, 64'hF0F0_F0F0_F0F0_F0F0, 64'hFF00_FF00_FF00_FF00,
                64'hF000_F000_F000_F000, 1'b0);
      add_entry("or_bits", op_or, 64'hF0F0_F0F0_F0F0_F0F0, 64'hFF00_FF00_FF00_FF00,
                64'hFFF0_FFF0_FFF0_FFF0, 1'b0);
      add_entry("xor_bits", op_xor, 64'hF0F0_F0F0_F0F0_F0F0, 64'hFF00_FF00_FF00_FF00,
                64'h0FF0_0FF0_0FF0_0FF0, 1'b0);
      add_entry("sll_mask", op_sll, 64'h8000_0000_0000_0001, 64'h44, 64'h10, 1'b0);  // amount 4
      add_entry("srl_4", op_srl, 64'h8000_0000_0000_0001, 64'd4, 64'h0800_0000_0000_0000, 1'b1);
      add_entry("sra_4", op_sra, 64'h8000_0000_0000_0001, 64'd4, 64'hF800_0000_0000_0000, 1'b0);
      add_entry("sll_63", op_sll, 64'd1, 64'd63, 64'h8000_0000_0000_0000, 1'b0);
      add_entry("srl_63", op_srl, 64'h8000_0000_0000_0000, 64'd63, 64'd1, 1'b0);
      add_entry("sra_63", op_sra, 64'h8000_0000_0000_0000, 64'd63, '1, 1'b0);
      add_entry("srl_0", op_srl, 64'h0123_4567_89AB_CDEF, 64'd0, 64'h0123_4567_89AB_CDEF, 1'b0);
      add_entry("slt_neg", op_slt, '1, 64'd1, 64'd1, 1'b0);
      add_entry("sltu_neg", op_sltu, '1, 64'd1, 64'd0, 1'b0);
      add_entry("slt_pos", op_slt, 64'd1, '1, 64'd0, 1'b0);
      add_entry("sltu_pos", op_sltu, 64'd1, '1, 64'd1, 1'b0);
      add_entry("min_s", op_min, '1, 64'd1, '1, 1'b0);
      add_entry("max_s", op_max, '1, 64'd1, 64'd1, 1'b0);
      add_entry("minu", op_minu, '1, 64'd1, 64'd1, 1'b0);
      add_entry("maxu", op_maxu, '1, 64'd1, '1, 1'b0);
      // first set bit in each segment and on its edges
      add_entry("clz_b63", op_clz, 64'h1 << 63, '0, 64'd0, 1'b1);
      add_entry("clz_b48", op_clz, 64'h1 << 48, '0, 64'd15, 1'b0);
      add_entry("clz_b47", op_clz, 64'h1 << 47, '0, 64'd16, 1'b0);
      add_entry("clz_b40", op_clz, 64'h1 << 40, '0, 64'd23, 1'b0);
      add_entry("clz_b25", op_clz, 64'h0000_0000_0300_0000, '0, 64'd38, 1'b0);
      add_entry("clz_b15", op_clz, 64'h1 << 15, '0, 64'd48, 1'b0);
      add_entry("clz_b0", op_clz, 64'h1, '0, 64'd63, 1'b0);
      add_entry("clz_zero", op_clz, 64'd0, '0, 64'd64, 1'b0);
      add_entry("ctz_b63", op_ctz, 64'h1 << 63, '0, 64'd63, 1'b0);
      add_entry("ctz_b52", op_ctz, 64'h00F0_0000_0000_0000, '0, 64'd52, 1'b0);
      add_entry("ctz_b48", op_ctz, 64'h1 << 48, '0, 64'd48, 1'b0);
      add_entry("ctz_b47", op_ctz, 64'h1 << 47, '0, 64'd47, 1'b0);
      add_entry("ctz_b20", op_ctz, 64'hFFFF_FFFF_FFF0_0000, '0, 64'd20, 1'b0);
      add_entry("ctz_b15", op_ctz, 64'h1 << 15, '0, 64'd15, 1'b0);
      add_entry("ctz_b0", op_ctz, 64'h1, '0, 64'd0, 1'b0);
      add_entry("ctz_zero", op_ctz, 64'd0, '0, 64'd64, 1'b0);
      add_entry("cpop_zero", op_cpop, 64'd0, '0, 64'd0, 1'b0);
      add_entry("cpop_ones", op_cpop, '1, '0, 64'd64, 1'b0);
      add_entry("cpop_sparse", op_cpop, 64'h8000_0001_0000_8001, '0, 64'd4, 1'b0);
      for (int r = 0; r < 12; r++)
      begin
         ra = {$random(seed), $random(seed)};
         rb = {$random(seed), $random(seed)};
         op = (r < 4) ? op_cpop : alu_op_e'(5'($unsigned($random(seed)) % 17));
         add_entry("random", op, ra, rb, expected_result(op, ra, rb), r == 6);
      end
   endtask

   // watchdog sized from the table length
   initial
   begin
      wait (table_ready);
      #((n_vec + n_idle + 10 + 20) * 8);
      $display("timeout: run did not finish within %0d cycles", n_vec + n_idle + 30);
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial
   begin
      rst_n_i  = 1'b0;
      valid_i  = 1'b0;
      req_i    = '0;
      exp_val  = '0;
      name_val = '0;
      build_table();
      table_ready = 1'b1;
      repeat (10) @(posedge clk);
      #1 rst_n_i = 1'b1;
      repeat (2) @(posedge clk);    // two idle cycles after reset
      #1;
      for (int i = 0; i < n_vec; i++)
      begin
         if (vecs[i].idle)
         begin
            valid_i = 1'b0;
            @(posedge clk);
            #1;
         end
         valid_i  = 1'b1;
         req_i    = '{vecs[i].op, vecs[i].a, vecs[i].b};
         exp_val  = vecs[i].exp;
         name_val = vecs[i].name;
         @(posedge clk);
         #1;
      end
      valid_i = 1'b0;
      repeat (3) @(posedge clk);
      $display("%0d mismatches, %0d protocol errors", mismatch_cnt, protocol_cnt);
      if (mismatch_cnt == 0 && protocol_cnt == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// File: list.f
design/alu_pkg.sv
design/alu_operand_stage.sv
design/bit_segment_counter.sv
design/segment_merge.sv
design/alu_execute.sv
design/alu_top.sv
bench/alu_checker.sv
bench/alu_tb.sv
